// File: reset_ctrl_top.f
reset_ctrl_pkg.sv
reset_flag_gen.sv
reset_domain_ctrl.sv
reset_ctrl_top.sv
tb_clock_gen.sv
reset_ctrl_assertions.sv
reset_ctrl_tb.sv

// File: run.sh
#!/bin/bash
# Build and run the reset sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module reset_ctrl_tb \
	-f reset_ctrl_top.f -o sim_reset_ctrl > build.log 2>&1 \
	&& ./obj_dir/sim_reset_ctrl > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test passed" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
exit 0

// File: reset_ctrl_tb.sv
`default_nettype none
`timescale 1ns/1ps

module reset_ctrl_tb;
	import reset_ctrl_pkg::*;

	localparam int ND   = DEF_NUM_DOMAINS;
	localparam int RW   = DEF_RESET_WAIT;
	localparam int OW   = DEF_OP_WAIT;
	localparam int IW   = DEF_INIT_WAIT;
	localparam int DRC  = DEF_DOMAIN_RESET_CYCLES;
	localparam int SS   = DEF_SYNC_STAGES;
	// Worst sequence from the system waits plus crossings and stretch in the 20 ns domain
	localparam int SEQ_NS = (RW + OW + IW + 4 * SS) * 8 + (DRC + 4 * SS + 4) * 20;
	localparam int WATCHDOG_NS = 6 * 3 * SEQ_NS + 3000;
	localparam reset_flags_t RST_FLAGS = '{clk_en: 1'b0, sync_rst: 1'b1, init: 1'b0};

	logic         clk;
	logic [1:0]   target_clk;
	logic         rst_n;
	logic         soft_rst_req;
	logic [ND-1:0] local_rst_req;
	reset_flags_t sys_flags;
	reset_flags_t target_flags [ND];
	reset_phase_e phase;

	int errors;
	int seq_done;
	int rst_len;
	int offset;
	int exp_seq;
	bit seq_active;
	reset_flags_t exp_flags;
	reset_phase_e exp_phase;

	tb_clock_gen clock_gen_i (
		.clk        (clk),
		.target_clk (target_clk),
		.rst_n      (rst_n)
	);

	reset_ctrl_top dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.target_clk    (target_clk),
		.soft_rst_req  (soft_rst_req),
		.local_rst_req (local_rst_req),
		.sys_flags     (sys_flags),
		.target_flags  (target_flags),
		.phase         (phase)
	);

	// Expected system flags a number of cycles after sync_rst fell
	function automatic reset_flags_t expected_flags(input int cyc);
		reset_flags_t f;
		f = '0;
		f.clk_en = 1'b1;
		if (cyc >= OW && cyc < OW + IW) begin
			f.init = 1'b1;
		end
		return f;
	endfunction

	// Expected phase a number of cycles after sync_rst fell
	function automatic reset_phase_e expected_phase(input int cyc);
		reset_phase_e p;
		if (cyc < OW) begin
			p = PHASE_STABLE;
		end else if (cyc < OW + IW) begin
			p = PHASE_INIT;
		end else begin
			p = PHASE_RUN;
		end
		return p;
	endfunction

	// System flag checker sampled away from the rising edge
	always @(negedge clk) begin
		if (!rst_n || sys_flags.sync_rst) begin
			if (sys_flags !== RST_FLAGS) begin
				$display("error: sys_flags got 0x%0h expected 0x%0h", sys_flags, RST_FLAGS);
				errors++;
			end
			if (phase !== PHASE_RESET) begin
				$display("error: phase got 0x%0h expected 0x%0h", phase, PHASE_RESET);
				errors++;
			end
			rst_len    = rst_n ? rst_len + 1 : 0;
			seq_active = 1'b0;
		end else begin
			if (!seq_active) begin
				if (rst_len < RW) begin
					$display("reset phase lasted only %0d cycles", rst_len);
					errors++;
				end
				seq_active = 1'b1;
				offset     = 0;
				rst_len    = 0;
			end
			exp_flags = expected_flags(offset);
			if (sys_flags !== exp_flags) begin
				$display("error: sys_flags got 0x%0h expected 0x%0h at offset %0d",
					sys_flags, exp_flags, offset);
				errors++;
			end
			exp_phase = expected_phase(offset);
			if (phase !== exp_phase) begin
				$display("error: phase got 0x%0h expected 0x%0h at offset %0d",
					phase, exp_phase, offset);
				errors++;
			end
			if (offset == OW + IW) begin
				seq_done++;
			end
			if (offset <= OW + IW) begin
				offset++;
			end
		end
	end

	// One checker per target domain in its own clock
	for (genvar d = 0; d < ND; d++) begin : g_watch
		int  errs;
		int  done;
		int  len;
		bit  init_seen;
		bit  prev_rst;

		initial begin
			errs = 0;
			done = 0;
			len = 0;
			init_seen = 1'b0;
			prev_rst = 1'b1;
		end

		always @(negedge target_clk[d]) begin
			if (target_flags[d].sync_rst) begin
				len++;
				init_seen = 1'b0;
				if (target_flags[d].init) begin
					$display("error: target_flags[%0d] got 0x%0h with init in reset",
						d, target_flags[d]);
					errs++;
				end
			end else if (!rst_n) begin
				$display("domain %0d left reset while rst_n was low", d);
				errs++;
			end else begin
				if (prev_rst && len < DRC) begin
					$display("domain %0d left reset after only %0d cycles", d, len);
					errs++;
				end
				len = 0;
				if (target_flags[d].init) begin
					init_seen = 1'b1;
					if (!target_flags[d].clk_en) begin
						$display("error: target_flags[%0d] got 0x%0h", d, target_flags[d]);
						errs++;
					end
				end else if (target_flags[d].clk_en && init_seen) begin
					done++;
					init_seen = 1'b0;
				end
			end
			prev_rst = target_flags[d].sync_rst;
		end
	end

	function automatic int total_errors();
		return errors + g_watch[0].errs + g_watch[1].errs;
	endfunction

	task automatic report(input string name, input int err_before);
		int n;
		n = total_errors() - err_before;
		if (n == 0) begin
			$display("%s: ok (phase %s)", name, phase.name());
		end else begin
			$display("%s: %0d errors", name, n);
		end
	endtask

	task automatic pulse_soft();
		@(posedge clk);
		#1 soft_rst_req = 1'b1;
		repeat (2) @(posedge clk);
		#1 soft_rst_req = 1'b0;
	endtask

	task automatic pulse_local(input int d);
		@(posedge target_clk[d]);
		#1 local_rst_req[d] = 1'b1;
		repeat (3) @(posedge target_clk[d]);
		#1 local_rst_req[d] = 1'b0;
	endtask

	// Wait for the next full sequence of the system flags
	task automatic wait_system();
		exp_seq++;
		wait (seq_done >= exp_seq);
		if (seq_done != exp_seq) begin
			$display("saw %0d completed sequences, expected %0d", seq_done, exp_seq);
			errors++;
		end
	endtask

	// Every domain must finish the same sequence exactly once
	task automatic wait_domains();
		wait (g_watch[0].done >= exp_seq && g_watch[1].done >= exp_seq);
		if (g_watch[0].done != exp_seq) begin
			$display("domain 0 saw %0d completed sequences, expected %0d",
				g_watch[0].done, exp_seq);
			errors++;
		end
		if (g_watch[1].done != exp_seq) begin
			$display("domain 1 saw %0d completed sequences, expected %0d",
				g_watch[1].done, exp_seq);
			errors++;
		end
	endtask

	// Wait for the next full sequence in the system and every domain
	task automatic wait_sequence();
		wait_system();
		wait_domains();
	endtask

	task automatic wait_phase(input reset_phase_e p);
		while (phase != p) begin
			@(negedge clk);
		end
	endtask

	task automatic idle_gap();
		repeat ($urandom % 4) @(posedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the sequences did not complete in time");
		$display("Test failed");
		$finish;
	end

	initial begin
		int e0;
		reset_phase_e targets [5];
		soft_rst_req  = 1'b0;
		local_rst_req = '0;
		errors   = 0;
		seq_done = 0;
		rst_len  = 0;
		offset   = 0;
		exp_seq  = 0;
		seq_active = 1'b0;
		void'($urandom(26));
		targets = '{PHASE_STABLE, PHASE_INIT, PHASE_RUN, PHASE_STABLE, PHASE_INIT};

		e0 = total_errors();
		wait (rst_n === 1'b1);
		repeat (2) @(posedge clk);
		report("test 1 reset hold", e0);

		e0 = total_errors();
		wait_system();
		report("test 2 power-up sequence", e0);

		e0 = total_errors();
		wait_domains();
		report("test 3 domain sequences", e0);

		e0 = total_errors();
		idle_gap();
		pulse_soft();
		wait_sequence();
		report("test 4 soft restart in run", e0);

		e0 = total_errors();
		idle_gap();
		pulse_local(1);
		wait_sequence();
		report("test 5 local restart", e0);

		e0 = total_errors();
		for (int k = 0; k < 5; k++) begin
			if (targets[k] != PHASE_RUN) begin
				// Restart once to reach the earlier phase and then hit it
				pulse_soft();
				wait_phase(targets[k]);
			end
			idle_gap();
			pulse_soft();
			wait_sequence();
		end
		report("test 6 random soft restarts", e0);

		$display("checks done: %0d sequences, %0d errors", seq_done, total_errors());
		if (total_errors() == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: reset_ctrl_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module reset_ctrl_assertions (
	input wire logic                         clk,
	input wire logic                         rst_n,
	input wire reset_ctrl_pkg::reset_flags_t sys_flags,
	input wire logic                         dom_rst_req
);

	// init and sync_rst are never both active
	assert property (@(posedge clk) disable iff (!rst_n)
		!(sys_flags.init && sys_flags.sync_rst))
		else $error("init asserted together with sync_rst");

	// init only while the clocks run
	assert property (@(posedge clk) disable iff (!rst_n)
		sys_flags.init |-> sys_flags.clk_en)
		else $error("init asserted without clk_en");

	// Domains are asked for reset whenever the system is in reset
	assert property (@(posedge clk) disable iff (!rst_n)
		sys_flags.sync_rst |-> dom_rst_req)
		else $error("dom_rst_req low while sync_rst is high");

endmodule

bind reset_ctrl_top reset_ctrl_assertions assertions_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.sys_flags   (sys_flags),
	.dom_rst_req (dom_rst_req)
);

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real SYS_HALF_NS = 4.0,
	parameter real T0_HALF_NS  = 6.0,
	parameter real T1_HALF_NS  = 10.0,
	parameter int  RESET_CYCLES = 10
) (
	output logic       clk,
	output logic [1:0] target_clk,
	output logic       rst_n
);

	initial begin
		clk        = 1'b0;
		target_clk = 2'b00;
		rst_n      = 1'b1;
		// Start high so the async reset sees a real falling edge
		#2 rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

	always #(SYS_HALF_NS) clk = ~clk;
	always #(T0_HALF_NS) target_clk[0] = ~target_clk[0];
	always #(T1_HALF_NS) target_clk[1] = ~target_clk[1];

endmodule

`default_nettype wire

// File: reset_ctrl_top.sv
`default_nettype none
`timescale 1ns/1ps

module reset_ctrl_top #(
	parameter int NUM_DOMAINS         = reset_ctrl_pkg::DEF_NUM_DOMAINS,
	parameter int RESET_WAIT          = reset_ctrl_pkg::DEF_RESET_WAIT,
	parameter int OP_WAIT             = reset_ctrl_pkg::DEF_OP_WAIT,
	parameter int INIT_WAIT           = reset_ctrl_pkg::DEF_INIT_WAIT,
	parameter int DOMAIN_RESET_CYCLES = reset_ctrl_pkg::DEF_DOMAIN_RESET_CYCLES,
	parameter int SYNC_STAGES         = reset_ctrl_pkg::DEF_SYNC_STAGES
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [NUM_DOMAINS-1:0]       target_clk,
	input  logic                         soft_rst_req,
	input  logic [NUM_DOMAINS-1:0]       local_rst_req,
	output reset_ctrl_pkg::reset_flags_t sys_flags,
	output reset_ctrl_pkg::reset_flags_t target_flags [NUM_DOMAINS],
	output reset_ctrl_pkg::reset_phase_e phase
);

	// Request to all domains, and the levels coming back
	logic                   dom_rst_req;
	logic [NUM_DOMAINS-1:0] dom_ack;
	logic [NUM_DOMAINS-1:0] dom_restart;

	reset_flag_gen #(
		.NUM_DOMAINS (NUM_DOMAINS),
		.RESET_WAIT  (RESET_WAIT),
		.OP_WAIT     (OP_WAIT),
		.INIT_WAIT   (INIT_WAIT),
		.SYNC_STAGES (SYNC_STAGES)
	) flag_gen_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.soft_rst_req (soft_rst_req),
		.dom_ack      (dom_ack),
		.dom_restart  (dom_restart),
		.sys_flags    (sys_flags),
		.dom_rst_req  (dom_rst_req),
		.phase        (phase)
	);

	// One controller per target clock
	for (genvar i = 0; i < NUM_DOMAINS; i++) begin : g_dom
		reset_domain_ctrl #(
			.DOMAIN_RESET_CYCLES (DOMAIN_RESET_CYCLES),
			.SYNC_STAGES         (SYNC_STAGES)
		) domain_ctrl_i (
			.target_clk    (target_clk[i]),
			.rst_n         (rst_n),
			.dom_rst_req   (dom_rst_req),
			.sys_flags     (sys_flags),
			.local_rst_req (local_rst_req[i]),
			.target_flags  (target_flags[i]),
			.dom_ack       (dom_ack[i]),
			.dom_restart   (dom_restart[i])
		);
	end

endmodule

`default_nettype wire

// File: reset_domain_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module reset_domain_ctrl #(
	parameter int DOMAIN_RESET_CYCLES = 4,
	parameter int SYNC_STAGES         = 2
) (
	input  logic                         target_clk,
	input  logic                         rst_n,
	input  logic                         dom_rst_req,
	input  reset_ctrl_pkg::reset_flags_t sys_flags,
	input  logic                         local_rst_req,
	output reset_ctrl_pkg::reset_flags_t target_flags,
	output logic                         dom_ack,
	output logic                         dom_restart
);
	import reset_ctrl_pkg::*;

	localparam int CNT_W = $clog2(DOMAIN_RESET_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DOMAIN_RESET_CYCLES - 1);

	// Local copy of rst_n that asserts at once and releases on target_clk
	logic [SYNC_STAGES-1:0] rst_sync;
	logic                   local_rst_n;

	logic [SYNC_STAGES-1:0] req_sync;
	reset_flags_t           flags_sync [SYNC_STAGES];
	reset_flags_t           flags_s;
	logic                   req_s;

	logic                   held;
	logic [CNT_W-1:0]       cnt;
	logic                   rst_out;
	logic                   ack_q;
	logic                   restart_q;

	always_ff @(posedge target_clk or negedge rst_n) begin
		if (!rst_n) begin
			rst_sync <= '0;
		end else begin
			rst_sync <= {rst_sync[SYNC_STAGES-2:0], 1'b1};
		end
	end

	assign local_rst_n = rst_sync[SYNC_STAGES-1];

	// Request and flags into target_clk
	// Both chains come out of reset in the reset state
	always_ff @(posedge target_clk or negedge local_rst_n) begin
		if (!local_rst_n) begin
			req_sync <= '1;
			for (int s = 0; s < SYNC_STAGES; s++) begin
				flags_sync[s] <= '{clk_en: 1'b0, sync_rst: 1'b1, init: 1'b0};
			end
		end else begin
			req_sync      <= {req_sync[SYNC_STAGES-2:0], dom_rst_req};
			flags_sync[0] <= sys_flags;
			for (int s = 1; s < SYNC_STAGES; s++) begin
				flags_sync[s] <= flags_sync[s-1];
			end
		end
	end

	assign flags_s = flags_sync[SYNC_STAGES-1];
	assign req_s   = req_sync[SYNC_STAGES-1];

	// Local reset follows the request at once and is then stretched
	assign rst_out = req_s | held;

	always_ff @(posedge target_clk or negedge local_rst_n) begin
		if (!local_rst_n) begin
			held <= 1'b1;
			cnt  <= '0;
		end else if (rst_out) begin
			if (cnt != CNT_LAST) begin
				cnt <= cnt + 1'b1;
			end
			// Release only after the minimum length and with the request gone
			held <= !((cnt >= CNT_LAST) && !req_s);
		end else begin
			held <= 1'b0;
			cnt  <= '0;
		end
	end

	// Acknowledge stays high while in reset and drops only after
	// the request has been seen low and the stretch is over
	always_ff @(posedge target_clk or negedge local_rst_n) begin
		if (!local_rst_n) begin
			ack_q     <= 1'b1;
			restart_q <= 1'b0;
		end else begin
			ack_q     <= rst_out;
			restart_q <= local_rst_req;
		end
	end

	assign target_flags.clk_en   = flags_s.clk_en;
	assign target_flags.sync_rst = rst_out;
	// init never overlaps the stretched reset
	assign target_flags.init     = flags_s.init & ~rst_out;

	assign dom_ack     = ack_q;
	assign dom_restart = restart_q;

endmodule

`default_nettype wire

// File: reset_flag_gen.sv
`default_nettype none
`timescale 1ns/1ps

module reset_flag_gen #(
	parameter int NUM_DOMAINS = 2,
	parameter int RESET_WAIT  = 6,
	parameter int OP_WAIT     = 8,
	parameter int INIT_WAIT   = 8,
	parameter int SYNC_STAGES = 2
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        soft_rst_req,
	input  logic [NUM_DOMAINS-1:0]      dom_ack,
	input  logic [NUM_DOMAINS-1:0]      dom_restart,
	output reset_ctrl_pkg::reset_flags_t sys_flags,
	output logic                        dom_rst_req,
	output reset_ctrl_pkg::reset_phase_e phase
);
	import reset_ctrl_pkg::*;

	localparam int MAX_WAIT_A = (RESET_WAIT > OP_WAIT) ? RESET_WAIT : OP_WAIT;
	localparam int MAX_WAIT   = (MAX_WAIT_A > INIT_WAIT) ? MAX_WAIT_A : INIT_WAIT;
	localparam int CNT_W      = $clog2(MAX_WAIT + 1);

	// Synchronizer chains for the domain levels, last stage is used
	logic [NUM_DOMAINS-1:0] ack_sync [SYNC_STAGES];
	logic [NUM_DOMAINS-1:0] restart_sync [SYNC_STAGES];
	logic [NUM_DOMAINS-1:0] restart_q;
	logic                   soft_q;

	logic                   all_ack;
	logic                   restart_rise;
	logic                   soft_rise;

	reset_phase_e           phase_q;
	reset_phase_e           phase_nxt;
	logic [CNT_W-1:0]       cnt;
	logic [CNT_W-1:0]       cnt_nxt;
	reset_flags_t           flags_q;
	logic                   req_q;

	function automatic reset_flags_t phase_flags(input reset_phase_e p);
		reset_flags_t f;
		f = '0;
		case (p)
			PHASE_RESET:  f.sync_rst = 1'b1;
			PHASE_STABLE: f.clk_en = 1'b1;
			PHASE_INIT: begin
				f.clk_en = 1'b1;
				f.init   = 1'b1;
			end
			default:      f.clk_en = 1'b1;
		endcase
		return f;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < SYNC_STAGES; s++) begin
				ack_sync[s]     <= '0;
				restart_sync[s] <= '0;
			end
			restart_q <= '0;
			soft_q    <= 1'b0;
		end else begin
			ack_sync[0]     <= dom_ack;
			restart_sync[0] <= dom_restart;
			for (int s = 1; s < SYNC_STAGES; s++) begin
				ack_sync[s]     <= ack_sync[s-1];
				restart_sync[s] <= restart_sync[s-1];
			end
			restart_q <= restart_sync[SYNC_STAGES-1];
			soft_q    <= soft_rst_req;
		end
	end

	assign all_ack      = &ack_sync[SYNC_STAGES-1];
	assign restart_rise = |(restart_sync[SYNC_STAGES-1] & ~restart_q);
	assign soft_rise    = soft_rst_req & ~soft_q;

	always_comb begin
		phase_nxt = phase_q;
		cnt_nxt   = cnt + 1'b1;
		case (phase_q)
			PHASE_RESET: begin
				// Hold the count once the minimum wait is over
				if (cnt >= CNT_W'(RESET_WAIT - 1)) begin
					cnt_nxt = cnt;
					if (all_ack) begin
						phase_nxt = PHASE_STABLE;
						cnt_nxt   = '0;
					end
				end
			end
			PHASE_STABLE: begin
				if (cnt == CNT_W'(OP_WAIT - 1)) begin
					phase_nxt = PHASE_INIT;
					cnt_nxt   = '0;
				end
			end
			PHASE_INIT: begin
				if (cnt == CNT_W'(INIT_WAIT - 1)) begin
					phase_nxt = PHASE_RUN;
					cnt_nxt   = '0;
				end
			end
			default: cnt_nxt = '0;
		endcase
		// Any new restart request starts over, except when already in reset
		if (phase_q != PHASE_RESET && (soft_rise || restart_rise)) begin
			phase_nxt = PHASE_RESET;
			cnt_nxt   = '0;
		end
	end

	// Flags and request are registered together with the phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= PHASE_RESET;
			cnt     <= '0;
			flags_q <= phase_flags(PHASE_RESET);
			req_q   <= 1'b1;
		end else begin
			phase_q <= phase_nxt;
			cnt     <= cnt_nxt;
			flags_q <= phase_flags(phase_nxt);
			req_q   <= (phase_nxt == PHASE_RESET);
		end
	end

	assign sys_flags   = flags_q;
	assign dom_rst_req = req_q;
	assign phase       = phase_q;

endmodule

`default_nettype wire

// File: reset_ctrl_pkg.sv
`default_nettype none

package reset_ctrl_pkg;

	// Sequencer phases, in the order the system walks through them
	typedef enum logic [1:0] {
		PHASE_RESET  = 2'd0,
		PHASE_STABLE = 2'd1,
		PHASE_INIT   = 2'd2,
		PHASE_RUN    = 2'd3
	} reset_phase_e;

	// Flag set seen by one clock domain
	typedef struct packed {
		logic clk_en;
		logic sync_rst;
		logic init;
	} reset_flags_t;

	// Number of target clock domains
	localparam int DEF_NUM_DOMAINS = 2;

	// Minimum system cycles spent in the reset phase
	localparam int DEF_RESET_WAIT = 6;

	// System cycles with clocks running before init
	// Must exceed the worst synchronizer delay into the slowest domain
	localparam int DEF_OP_WAIT = 8;

	// Length of the init pulse in system cycles
	localparam int DEF_INIT_WAIT = 8;

	// Minimum local reset length in target cycles
	localparam int DEF_DOMAIN_RESET_CYCLES = 4;

	// Flip-flops per clock crossing
	localparam int DEF_SYNC_STAGES = 2;

endpackage

`default_nettype wire
